// File: autoAnim.sv
`timescale 1ns/1ps

module autoAnim(
	input logic CLK_24M,
	input logic nRESET,
	input logic vBlank,
	input logic [7:0] speed,
	input logic disableAnim,
	output lspcPkg::aaCount value
);

	logic vBlankPrev;
	logic frameRise;
	logic [7:0] frameCnt;

	assign frameRise = vBlank && !vBlankPrev;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			vBlankPrev <= 1'b0;
			frameCnt <= '0;
			value <= '0;
		end
		else
		begin
			vBlankPrev <= vBlank;
			if (frameRise)
			begin
				// Speed 0 and 1 both step every frame
				if (({1'b0, frameCnt} + 9'd1) >= {1'b0, speed})
				begin
					frameCnt <= '0;
					if (!disableAnim)
						value <= value + 3'd1;
				end
				else
					frameCnt <= frameCnt + 8'd1;
			end
		end
	end

endmodule

// File: compile.f
+incdir+.
lspcPkg.sv
videoSync.sv
rasterTimer.sv
autoAnim.sv
vramPort.sv
lspcRegs.sv
lspcTop.sv
tbLspc.sv

// File: lspcPkg.sv
package lspcPkg;

	// Raster position, horizontal or vertical
	typedef logic [8:0] rasterCnt;

	typedef logic [14:0] vramAddr;

	// VRAM word, also used for register values
	typedef logic [15:0] vramWord;

	typedef logic [31:0] timerVal;

	typedef logic [2:0] aaCount;

	// Beam position and sync outputs
	typedef struct packed {
		rasterCnt hCount;
		rasterCnt vCount;
		logic hSync;
		logic vSync;
		logic vBlank;
	} rasterPos;

	// Single-cycle host access to VRAM
	typedef struct packed {
		logic valid;
		logic write;
		vramAddr addr;
		vramWord wdata;
	} vramReq;

	typedef struct packed {
		timerVal reloadVal;
		logic loadNow;
		logic reloadOnZero;
		logic intEnable;
		logic stopInBorder;
	} timerCtrl;

	typedef enum logic [0:0] {wrIdle, wrResp} axiWrState;

endpackage

// File: lspcRegs.sv
`timescale 1ns/1ps
`include "lspc_cfg.svh"

module lspcRegs(
	input logic CLK_24M,
	input logic nRESET,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input lspcPkg::vramWord wdata,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output lspcPkg::vramWord rdata,
	output logic rvalid,
	input logic rready,
	output logic [1:0] rresp,
	input lspcPkg::rasterPos pos,
	input lspcPkg::vramWord vramRdata,
	input logic vramBusy,
	input logic timerZero,
	input lspcPkg::aaCount aaValue,
	output lspcPkg::vramReq vramCmd,
	output lspcPkg::timerCtrl tmr,
	output logic [7:0] aaSpeed,
	output logic aaDisable,
	output logic irqVblank,
	output logic irqTimer
);

	lspcPkg::axiWrState wrState;
	lspcPkg::vramAddr vramAddrReg;
	lspcPkg::vramWord modStep;
	lspcPkg::timerVal timerReload;
	lspcPkg::vramWord readValue;
	logic [2:0] timerIntMode;
	logic timerIntEn;
	logic timerLoadReq;
	logic timerStop;
	logic vBlankPrev;
	logic vBlankRise;
	logic wrFire;
	logic arFire;
	logic ackVblank;
	logic ackTimer;

	// Write taken only with both channels valid and VRAM idle
	assign wrFire = awvalid && wvalid && (wrState == lspcPkg::wrIdle) && !vramBusy;
	assign awready = wrFire;
	assign wready = wrFire;
	assign bvalid = (wrState == lspcPkg::wrResp);
	assign bresp = 2'b00;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			wrState <= lspcPkg::wrIdle;
		else if (wrFire)
			wrState <= lspcPkg::wrResp;
		else if (bvalid && bready)
			wrState <= lspcPkg::wrIdle;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			vramAddrReg <= '0;
			modStep <= '0;
			aaSpeed <= '0;
			timerIntMode <= '0;
			timerIntEn <= 1'b0;
			aaDisable <= 1'b0;
			timerReload <= '0;
			timerLoadReq <= 1'b0;
			timerStop <= 1'b0;
			vramCmd.valid <= 1'b0;
		end
		else
		begin
			vramCmd.valid <= 1'b0;
			timerLoadReq <= 1'b0;
			if (wrFire)
			begin
				case (awaddr)
					`LSPC_REG_VRAMADDR:
					begin
						// New address prefetches its word
						vramAddrReg <= wdata[14:0];
						vramCmd.valid <= 1'b1;
						vramCmd.write <= 1'b0;
						vramCmd.addr <= wdata[14:0];
					end
					`LSPC_REG_VRAMRW:
					begin
						vramCmd.valid <= 1'b1;
						vramCmd.write <= 1'b1;
						vramCmd.addr <= vramAddrReg;
						vramCmd.wdata <= wdata;
						vramAddrReg <= vramAddrReg + modStep[14:0];
					end
					`LSPC_REG_VRAMMOD: modStep <= wdata;
					`LSPC_REG_MODE:
					begin
						aaSpeed <= wdata[15:8];
						timerIntMode <= wdata[7:5];
						timerIntEn <= wdata[4];
						aaDisable <= wdata[3];
					end
					`LSPC_REG_TIMERHI: timerReload[31:16] <= wdata;
					`LSPC_REG_TIMERLO:
					begin
						timerReload[15:0] <= wdata;
						timerLoadReq <= timerIntMode[0];
					end
					`LSPC_REG_TIMERSTOP: timerStop <= wdata[0];
					default: ;
				endcase
			end
		end
	end

	// Bit 2 acks vblank, bit 1 acks the raster timer
	assign ackVblank = wrFire && (awaddr == `LSPC_REG_IRQACK) && wdata[2];
	assign ackTimer = wrFire && (awaddr == `LSPC_REG_IRQACK) && wdata[1];
	assign vBlankRise = pos.vBlank && !vBlankPrev;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			vBlankPrev <= 1'b0;
			irqVblank <= 1'b0;
			irqTimer <= 1'b0;
		end
		else
		begin
			vBlankPrev <= pos.vBlank;
			if (ackVblank)
				irqVblank <= 1'b0;
			else if (vBlankRise)
				irqVblank <= 1'b1;
			if (ackTimer)
				irqTimer <= 1'b0;
			else if (timerZero)
				irqTimer <= 1'b1;
		end
	end

	// Mode bit 1 also reloads at the start of vblank
	assign tmr = '{
		reloadVal: timerReload,
		loadNow: timerLoadReq || (timerIntMode[1] && vBlankRise),
		reloadOnZero: timerIntMode[2],
		intEnable: timerIntEn,
		stopInBorder: timerStop && (`LSPC_VIDEO_MODE != 0)
	};

	always_comb
	begin
		case (araddr)
			`LSPC_REG_VRAMADDR, `LSPC_REG_VRAMRW: readValue = vramRdata;
			`LSPC_REG_VRAMMOD: readValue = modStep;
			`LSPC_REG_MODE: readValue = {pos.vCount, 3'b000, 1'(`LSPC_VIDEO_MODE), aaValue};
			`LSPC_REG_TIMERHI: readValue = timerReload[31:16];
			`LSPC_REG_TIMERLO: readValue = timerReload[15:0];
			`LSPC_REG_IRQACK: readValue = {13'd0, irqVblank, irqTimer, 1'b0};
			`LSPC_REG_TIMERSTOP: readValue = {15'd0, timerStop};
			default: readValue = '0;
		endcase
	end

	// One read in flight, held until rready
	assign arFire = arvalid && !rvalid;
	assign arready = arFire;
	assign rresp = 2'b00;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			rvalid <= 1'b0;
		else if (arFire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (arFire)
			rdata <= readValue;
	end

	noCmdWhileBusy: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		vramCmd.valid |-> !vramBusy);

	bvalidAfterWrite: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$rose(bvalid) |-> $past(wrFire));

endmodule

// File: lspcTop.sv
`timescale 1ns/1ps

module lspcTop(
	input logic CLK_24M,
	input logic nRESET,
	input logic [3:0] awaddr,
	input logic awvalid,
	output logic awready,
	input lspcPkg::vramWord wdata,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic [3:0] araddr,
	input logic arvalid,
	output logic arready,
	output lspcPkg::vramWord rdata,
	output logic rvalid,
	input logic rready,
	output logic [1:0] rresp,
	output logic hSync,
	output logic vSync,
	output logic vBlank,
	output logic irqVblank,
	output logic irqTimer
);

	lspcPkg::rasterPos pos;
	lspcPkg::vramReq vramCmd;
	lspcPkg::vramWord vramRdata;
	lspcPkg::timerCtrl tmr;
	lspcPkg::aaCount aaValue;
	logic pixTick;
	logic vramBusy;
	logic timerZero;
	logic [7:0] aaSpeed;
	logic aaDisable;

	lspcRegs regBlock(
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready), .rresp(rresp),
		.pos(pos), .vramRdata(vramRdata), .vramBusy(vramBusy),
		.timerZero(timerZero), .aaValue(aaValue), .vramCmd(vramCmd), .tmr(tmr),
		.aaSpeed(aaSpeed), .aaDisable(aaDisable),
		.irqVblank(irqVblank), .irqTimer(irqTimer)
	);

	videoSync syncGen(.CLK_24M(CLK_24M), .nRESET(nRESET), .pixTick(pixTick), .pos(pos));

	rasterTimer rasterTmr(
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.pixTick(pixTick), .pos(pos), .ctrl(tmr), .zero(timerZero)
	);

	autoAnim animCnt(
		.CLK_24M(CLK_24M), .nRESET(nRESET), .vBlank(pos.vBlank),
		.speed(aaSpeed), .disableAnim(aaDisable), .value(aaValue)
	);

	vramPort vram(
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.cmd(vramCmd), .rdata(vramRdata), .busy(vramBusy)
	);

	assign hSync = pos.hSync;
	assign vSync = pos.vSync;
	assign vBlank = pos.vBlank;

endmodule

// File: lspc_cfg.svh
`ifndef LSPC_CFG_SVH
`define LSPC_CFG_SVH

// Raster geometry in pixel ticks per line and lines per frame
`define LSPC_H_TOTAL 384
`define LSPC_H_SYNC 32
`define LSPC_V_TOTAL 264
`define LSPC_V_BLANK_START 240
`define LSPC_V_SYNC 8

// 1 for PAL, 0 for NTSC
`define LSPC_VIDEO_MODE 1

`define LSPC_VRAM_WORDS 32768

// Register byte offsets on the host bus
`define LSPC_REG_VRAMADDR 4'h0
`define LSPC_REG_VRAMRW 4'h2
`define LSPC_REG_VRAMMOD 4'h4
`define LSPC_REG_MODE 4'h6
`define LSPC_REG_TIMERHI 4'h8
`define LSPC_REG_TIMERLO 4'hA
`define LSPC_REG_IRQACK 4'hC
`define LSPC_REG_TIMERSTOP 4'hE

`endif

// File: rasterTimer.sv
`timescale 1ns/1ps

module rasterTimer(
	input logic CLK_24M,
	input logic nRESET,
	input logic pixTick,
	input lspcPkg::rasterPos pos,
	input lspcPkg::timerCtrl ctrl,
	output logic zero
);

	lspcPkg::timerVal count;
	logic running;

	// Stopped in the vertical border only when asked to
	assign running = !pos.vBlank || !ctrl.stopInBorder;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			count <= '0;
			zero <= 1'b0;
		end
		else
		begin
			zero <= 1'b0;
			if (ctrl.loadNow)
			begin
				// Immediate load wins over the tick
				count <= ctrl.reloadVal;
			end
			else if (pixTick && running)
			begin
				if (count == '0)
				begin
					zero <= ctrl.intEnable;
					if (ctrl.reloadOnZero)
						count <= ctrl.reloadVal;
				end
				else
					count <= count - 32'd1;
			end
		end
	end

	// Zero comes from a pixel tick, so it never lasts two cycles
	zeroIsPulse: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		zero |=> !zero);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the LSPC testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tbLspc -f compile.f -o simLspc \
	&& ./obj_dir/simLspc \
	|| { echo "build or simulation failed"; exit 1; }

// File: tbLspc.sv
`timescale 1ns/1ps
`include "lspc_cfg.svh"

module tbLspc;

	localparam int frameCycles = `LSPC_H_TOTAL * `LSPC_V_TOTAL * 4;
	localparam int axiTimeout = 64;

	logic CLK_24M;
	logic nRESET;
	logic [3:0] awaddr;
	logic awvalid;
	logic awready;
	lspcPkg::vramWord wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic [3:0] araddr;
	logic arvalid;
	logic arready;
	lspcPkg::vramWord rdata;
	logic rvalid;
	logic rready;
	logic [1:0] rresp;
	logic hSync;
	logic vSync;
	logic vBlank;
	logic irqVblank;
	logic irqTimer;

	// Expected VRAM contents for the words written so far
	lspcPkg::vramWord vramModel [lspcPkg::vramAddr];
	lspcPkg::vramAddr addrList [8];

	lspcTop DUT(.*);

	always #50 CLK_24M = !CLK_24M;

	// Address step wraps inside the 32K-word VRAM
	function automatic lspcPkg::vramAddr nextAddr(lspcPkg::vramAddr addr, lspcPkg::vramWord step);
		return addr + step[14:0];
	endfunction

	// Mode register holds line, three zero bits, video mode and animation frame
	function automatic lspcPkg::vramWord modeWord(lspcPkg::rasterCnt line, lspcPkg::aaCount frame);
		return {line, 3'b000, 1'(`LSPC_VIDEO_MODE), frame};
	endfunction

	// One step per completed division of the frame count
	function automatic lspcPkg::aaCount animAfter(lspcPkg::aaCount base, int frames, int speed);
		int steps;
		steps = (speed <= 1) ? frames : frames / speed;
		return base + lspcPkg::aaCount'(steps);
	endfunction

	// Reload N counts down to 0 and fires on one more tick
	function automatic int timerTicks(int reload);
		return reload + 1;
	endfunction

	task automatic stopRun;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic reportError(string what);
		$display("ERROR at %0t: %s", $time, what);
		stopRun();
	endtask

	task automatic checkWord(string name, lspcPkg::vramWord got, lspcPkg::vramWord exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkCount(string name, lspcPkg::aaCount got, lspcPkg::aaCount exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			stopRun();
		end
	endtask

	// Request stays up during the stall to probe back-pressure
	task automatic axiWrite(input logic [3:0] addr, input lspcPkg::vramWord data, input int stall);
		int waitCnt;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		waitCnt = 0;
		@(negedge CLK_24M);
		while (!bvalid)
		begin
			waitCnt++;
			if (waitCnt > axiTimeout)
				reportError("AXI write was never accepted");
			@(negedge CLK_24M);
		end
		checkFlag("bresp okay", bresp == 2'b00, 1'b1);
		repeat (stall)
		begin
			@(negedge CLK_24M);
			checkFlag("bvalid", bvalid, 1'b1);
			checkFlag("awready", awready, 1'b0);
			checkFlag("wready", wready, 1'b0);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge CLK_24M);
		bready = 1'b0;
		checkFlag("bvalid", bvalid, 1'b0);
	endtask

	task automatic axiRead(input logic [3:0] addr, input int stall, output lspcPkg::vramWord data);
		int waitCnt;
		araddr = addr;
		arvalid = 1'b1;
		waitCnt = 0;
		@(negedge CLK_24M);
		while (!rvalid)
		begin
			waitCnt++;
			if (waitCnt > axiTimeout)
				reportError("AXI read was never answered");
			@(negedge CLK_24M);
		end
		data = rdata;
		checkFlag("rresp okay", rresp == 2'b00, 1'b1);
		repeat (stall)
		begin
			@(negedge CLK_24M);
			checkFlag("rvalid", rvalid, 1'b1);
			checkFlag("arready", arready, 1'b0);
			checkWord("rdata", rdata, data);
		end
		arvalid = 1'b0;
		rready = 1'b1;
		@(negedge CLK_24M);
		rready = 1'b0;
		checkFlag("rvalid", rvalid, 1'b0);
	endtask

	task automatic waitForBlank(input logic level);
		int waitCnt;
		waitCnt = 0;
		while (vBlank !== level)
		begin
			@(negedge CLK_24M);
			waitCnt++;
			if (waitCnt > frameCycles)
				reportError("vBlank did not change within a frame");
		end
	endtask

	task automatic waitFrames(input int count);
		repeat (count)
		begin
			waitForBlank(1'b0);
			waitForBlank(1'b1);
		end
	endtask

	initial
	begin
		int i;
		int reload;
		int cycles;
		int speed;
		int frames;
		lspcPkg::vramWord step;
		lspcPkg::vramWord word;
		lspcPkg::vramWord readWord;
		lspcPkg::vramAddr addr;
		lspcPkg::aaCount base;

		void'($urandom(32'hb8fd));
		CLK_24M = 1'b0;
		nRESET = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (10) @(negedge CLK_24M);
		nRESET = 1'b1;
		@(negedge CLK_24M);

		// Reset state
		checkFlag("irqVblank", irqVblank, 1'b0);
		checkFlag("irqTimer", irqTimer, 1'b0);
		checkFlag("hSync", hSync, 1'b0);
		checkFlag("vSync", vSync, 1'b0);
		axiRead(`LSPC_REG_VRAMMOD, 0, readWord);
		checkWord("VRAM modulo", readWord, 16'h0000);

		// VRAM writes through the data register with a random step
		step = lspcPkg::vramWord'($urandom);
		axiWrite(`LSPC_REG_VRAMMOD, step, 0);
		addr = lspcPkg::vramAddr'($urandom);
		axiWrite(`LSPC_REG_VRAMADDR, {1'b0, addr}, 0);
		for (i = 0; i < 8; i++)
		begin
			word = lspcPkg::vramWord'($urandom);
			addrList[i] = addr;
			vramModel[addr] = word;
			axiWrite(`LSPC_REG_VRAMRW, word, 0);
			addr = nextAddr(addr, step);
		end
		for (i = 0; i < 8; i++)
		begin
			axiWrite(`LSPC_REG_VRAMADDR, {1'b0, addrList[i]}, 0);
			// Prefetched word lands two cycles after the response
			repeat (2) @(negedge CLK_24M);
			axiRead(`LSPC_REG_VRAMRW, 0, readWord);
			checkWord("VRAM read data", readWord, vramModel[addrList[i]]);
		end

		// Flag follows the vBlank rise by one cycle
		waitForBlank(1'b1);
		checkFlag("irqVblank", irqVblank, 1'b0);
		@(negedge CLK_24M);
		checkFlag("irqVblank", irqVblank, 1'b1);
		axiRead(`LSPC_REG_MODE, 0, readWord);
		// First vBlank rise of the run steps the animation once at speed 0
		checkWord("mode register", readWord,
			modeWord(9'(`LSPC_V_BLANK_START), animAfter(3'd0, 1, 0)));
		axiWrite(`LSPC_REG_IRQACK, 16'h0004, 0);
		checkFlag("irqVblank", irqVblank, 1'b0);

		// Park the timer on a large count before enabling its interrupt
		waitForBlank(1'b0);
		axiWrite(`LSPC_REG_MODE, 16'h0020, 0);
		axiWrite(`LSPC_REG_TIMERHI, 16'h0001, 0);
		axiWrite(`LSPC_REG_TIMERLO, 16'h0000, 0);
		axiWrite(`LSPC_REG_MODE, 16'h0030, 0);
		reload = int'($urandom_range(200, 16));
		axiWrite(`LSPC_REG_TIMERHI, 16'h0000, 0);
		axiWrite(`LSPC_REG_TIMERLO, lspcPkg::vramWord'(reload), 0);
		cycles = 0;
		while (irqTimer !== 1'b1)
		begin
			@(negedge CLK_24M);
			cycles++;
			if (cycles > 4 * timerTicks(reload) + 16)
				reportError("raster timer interrupt never came");
		end
		// Two cycles of load and flag latency round into the interval
		checkWord("timer interval", lspcPkg::vramWord'((cycles + 2) / 4),
			lspcPkg::vramWord'(timerTicks(reload)));
		axiWrite(`LSPC_REG_MODE, 16'h0020, 0);
		axiWrite(`LSPC_REG_IRQACK, 16'h0002, 0);
		checkFlag("irqTimer", irqTimer, 1'b0);

		// Auto-animation divided by a random speed
		speed = int'($urandom_range(3, 1));
		frames = int'($urandom_range(5, 2));
		axiWrite(`LSPC_REG_MODE, {8'(speed), 8'h00}, 0);
		axiRead(`LSPC_REG_MODE, 0, readWord);
		base = readWord[2:0];
		waitFrames(frames);
		// Counter steps one cycle after the vBlank rise
		@(negedge CLK_24M);
		axiRead(`LSPC_REG_MODE, 0, readWord);
		checkCount("aaCount", readWord[2:0], animAfter(base, frames, speed));

		// Frozen animation
		axiWrite(`LSPC_REG_MODE, 16'h0108, 0);
		axiRead(`LSPC_REG_MODE, 0, readWord);
		base = readWord[2:0];
		waitFrames(3);
		axiRead(`LSPC_REG_MODE, 0, readWord);
		checkCount("aaCount with animation off", readWord[2:0], base);

		// Responses held back for random stretches
		for (i = 0; i < 6; i++)
		begin
			step = lspcPkg::vramWord'($urandom);
			word = lspcPkg::vramWord'($urandom);
			axiWrite(`LSPC_REG_VRAMMOD, step, int'($urandom_range(8, 1)));
			axiWrite(`LSPC_REG_TIMERHI, word, int'($urandom_range(8, 1)));
			axiRead(`LSPC_REG_VRAMMOD, int'($urandom_range(8, 1)), readWord);
			checkWord("VRAM modulo", readWord, step);
			axiRead(`LSPC_REG_TIMERHI, int'($urandom_range(8, 1)), readWord);
			checkWord("timer reload high", readWord, word);
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: videoSync.sv
`timescale 1ns/1ps
`include "lspc_cfg.svh"

module videoSync(
	input logic CLK_24M,
	input logic nRESET,
	output logic pixTick,
	output lspcPkg::rasterPos pos
);

	localparam lspcPkg::rasterCnt hLast = 9'(`LSPC_H_TOTAL - 1);
	localparam lspcPkg::rasterCnt vLast = 9'(`LSPC_V_TOTAL - 1);
	localparam lspcPkg::rasterCnt hSyncStart = 9'(`LSPC_H_TOTAL - `LSPC_H_SYNC);
	localparam lspcPkg::rasterCnt vSyncStart = 9'(`LSPC_V_TOTAL - `LSPC_V_SYNC);

	logic [1:0] tickDiv;
	lspcPkg::rasterCnt hCount;
	lspcPkg::rasterCnt vCount;

	// 24 MHz down to the 6 MHz pixel rate
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			tickDiv <= 2'd0;
		else
			tickDiv <= tickDiv + 2'd1;
	end

	assign pixTick = (tickDiv == 2'd3);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (pixTick)
		begin
			if (hCount == hLast)
			begin
				hCount <= '0;
				// Next line, wrap at end of frame
				vCount <= (vCount == vLast) ? '0 : vCount + 9'd1;
			end
			else
				hCount <= hCount + 9'd1;
		end
	end

	// Sync pulses sit at the end of the line and of the frame
	assign pos.hCount = hCount;
	assign pos.vCount = vCount;
	assign pos.hSync = (hCount >= hSyncStart);
	assign pos.vSync = (vCount >= vSyncStart);
	assign pos.vBlank = (vCount >= 9'(`LSPC_V_BLANK_START));

	hCountRange: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		hCount < 9'(`LSPC_H_TOTAL));

endmodule

// File: vramPort.sv
`timescale 1ns/1ps
`include "lspc_cfg.svh"

module vramPort(
	input logic CLK_24M,
	input logic nRESET,
	input lspcPkg::vramReq cmd,
	output lspcPkg::vramWord rdata,
	output logic busy
);

	lspcPkg::vramWord mem [`LSPC_VRAM_WORDS];
	lspcPkg::vramAddr rdAddr;
	logic addrStage;
	logic dataStage;
	logic readReq;

	assign readReq = cmd.valid && !cmd.write;

	// Writes complete in the request cycle
	always_ff @(posedge CLK_24M)
	begin
		if (cmd.valid && cmd.write)
			mem[cmd.addr] <= cmd.wdata;
	end

	// Stage flags of the read pipeline
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			addrStage <= 1'b0;
			dataStage <= 1'b0;
		end
		else
		begin
			addrStage <= readReq;
			dataStage <= addrStage;
		end
	end

	// Address register, then data register
	always_ff @(posedge CLK_24M)
	begin
		if (readReq)
			rdAddr <= cmd.addr;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (addrStage)
			rdata <= mem[rdAddr];
	end

	// High from the address stage until rdata settles
	assign busy = addrStage || dataStage;

	readBusyTwo: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		readReq |=> busy [*2] ##1 !busy);

endmodule
